// ==== src/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

  // host register port
  localparam int io_addr_width = 8;
  localparam int io_data_width = 32;

  // scan length in words, up to 256
  localparam int len_width = 9;

  // rule table
  localparam int rule_count     = 8;
  localparam int rule_idx_width = 3;

  // register offsets on the host port
  typedef enum logic [io_addr_width-1:0] {
    reg_ctrl = 8'h00,
    reg_len  = 8'h04,
    reg_addr = 8'h08,
    reg_hot  = 8'h0C,
    reg_idx  = 8'h10,
    reg_err  = 8'h14
  } reg_addr_e;

  // reg_ctrl write bits
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_stop_bit  = 4;

  // reg_ctrl read bits
  localparam int ctrl_busy_bit  = 1;
  localparam int ctrl_done_bit  = 8;
  localparam int ctrl_match_bit = 9;

  // reg_idx valid flag, above the index field
  localparam int idx_valid_bit = 8;

  // reg_err flag, also the clear bit on write
  localparam int err_bit = 0;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // packet memory geometry
  localparam int mem_addr_width = 8;

  // word width, shared with the rule words
  localparam int mem_data_width = 32;

  // read engine states
  typedef enum logic [1:0] {
    dma_idle,
    dma_fetch,
    dma_drain
  } dma_state_e;

endpackage

`default_nettype wire

// ==== src/accel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  io_en,
  input  logic                                  io_wen,
  input  logic [accel_pkg::io_addr_width-1:0]   io_addr,
  input  logic [accel_pkg::io_data_width-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_width-1:0]   io_rd_data,
  output logic                                  io_rd_valid,
  output logic                                  cmd_start,
  output logic                                  cmd_stop,
  output logic [accel_pkg::len_width-1:0]       cmd_len,
  output logic [mem_pkg::mem_addr_width-1:0]    cmd_addr,
  input  logic                                  busy,
  input  logic                                  desc_error,
  input  logic                                  scan_done,
  input  logic                                  hit_valid,
  input  logic [accel_pkg::rule_count-1:0]      hit_mask,
  input  logic [accel_pkg::rule_idx_width-1:0]  hit_idx,
  output logic                                  error
);
  import accel_pkg::*;
  import mem_pkg::*;

  logic                      wr_en;
  logic                      rd_en;
  logic                      start_ok;
  logic                      done;
  logic                      match;
  logic                      idx_valid;
  logic                      rd_stall;
  logic [rule_count-1:0]     hot;
  logic [rule_idx_width-1:0] idx;
  logic [io_data_width-1:0]  rd_mux;

  assign wr_en = io_en && io_wen;
  assign rd_en = io_en && !io_wen;

  // command pulses last exactly as long as the io_en strobe
  assign cmd_start = wr_en && (io_addr == reg_ctrl) && io_wr_data[ctrl_start_bit];
  assign cmd_stop  = wr_en && (io_addr == reg_ctrl) && io_wr_data[ctrl_stop_bit];

  // a rejected start leaves the running scan's status alone
  assign start_ok = cmd_start && !desc_error;

  assign match = |hot;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_len  <= '0;
      cmd_addr <= '0;
    end else if (wr_en) begin
      if (io_addr == reg_len) begin
        cmd_len <= io_wr_data[len_width-1:0];
      end
      if (io_addr == reg_addr) begin
        cmd_addr <= io_wr_data[mem_addr_width-1:0];
      end
    end
  end

  // sticky scan status, cleared by an accepted start
  always_ff @(posedge clk) begin
    if (rst) begin
      done      <= 1'b0;
      hot       <= '0;
      idx_valid <= 1'b0;
    end else if (start_ok) begin
      done      <= 1'b0;
      hot       <= '0;
      idx_valid <= 1'b0;
    end else begin
      if (scan_done) begin
        done <= 1'b1;
      end
      if (hit_valid) begin
        hot <= hot | hit_mask;
        if (|hit_mask) begin
          idx_valid <= 1'b1;
        end
      end
    end
  end

  // first matching word wins, matcher already picked its lowest rule
  always_ff @(posedge clk) begin
    if (hit_valid && (|hit_mask) && !idx_valid) begin
      idx <= hit_idx;
    end
  end

  // error set beats a clear in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      error <= 1'b0;
    end else if (desc_error) begin
      error <= 1'b1;
    end else if (wr_en && (io_addr == reg_err) && io_wr_data[err_bit]) begin
      error <= 1'b0;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (io_addr)
      reg_ctrl: begin
        rd_mux[ctrl_busy_bit]  = busy;
        rd_mux[ctrl_done_bit]  = done;
        rd_mux[ctrl_match_bit] = match;
      end
      reg_len:  rd_mux[len_width-1:0] = cmd_len;
      reg_addr: rd_mux[mem_addr_width-1:0] = cmd_addr;
      reg_hot:  rd_mux[rule_count-1:0] = hot;
      reg_idx: begin
        rd_mux[rule_idx_width-1:0] = idx;
        rd_mux[idx_valid_bit]      = idx_valid;
      end
      reg_err:  rd_mux[err_bit] = error;
      default:  rd_mux = '0;
    endcase
  end

  // reg_hot waits for done, the host keeps io_addr steady meanwhile
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
    end else begin
      io_rd_valid <= 1'b0;
      if (rd_stall) begin
        if (done) begin
          io_rd_valid <= 1'b1;
          rd_stall    <= 1'b0;
        end
      end else if (rd_en) begin
        if ((io_addr == reg_hot) && !done) begin
          rd_stall <= 1'b1;
        end else begin
          io_rd_valid <= 1'b1;
        end
      end
    end
  end

  // refreshed every stalled cycle so the released word has the final hits
  always_ff @(posedge clk) begin
    if (rd_en || rd_stall) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cmd_start,
  input  logic                            cmd_stop,
  input  logic [accel_pkg::len_width-1:0] cmd_len,
  input  logic                            last,
  output logic                            load,
  output logic                            step,
  output logic                            busy,
  output logic                            desc_error,
  output logic                            scan_done,
  output logic                            mem_en,
  output logic                            word_last
);
  import mem_pkg::*;

  dma_state_e state;
  logic       accept;
  logic       last_q;

  assign busy = (state != dma_idle);

  // overlapping or empty descriptors are refused
  assign desc_error = cmd_start && (busy || (cmd_len == '0));
  assign accept     = cmd_start && !cmd_stop && !desc_error;

  // first fetch cycle is spent loading the counter
  assign mem_en = (state == dma_fetch) && !load;
  assign step   = mem_en;

  // last word seen at the matcher output, or an abort
  assign scan_done = ((state == dma_drain) && last_q) || (cmd_stop && busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dma_idle;
      load      <= 1'b0;
      word_last <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      load      <= accept;
      word_last <= mem_en && last;
      last_q    <= word_last;
      case (state)
        dma_idle: begin
          if (accept) begin
            state <= dma_fetch;
          end
        end
        dma_fetch: begin
          if (cmd_stop) begin
            state <= dma_idle;
          end else if (mem_en && last) begin
            state <= dma_drain;
          end
        end
        dma_drain: begin
          if (cmd_stop || last_q) begin
            state <= dma_idle;
          end
        end
        default: state <= dma_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/len_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module len_counter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               load,
  input  logic                               step,
  input  logic [mem_pkg::mem_addr_width-1:0] cmd_addr,
  input  logic [accel_pkg::len_width-1:0]    cmd_len,
  output logic [mem_pkg::mem_addr_width-1:0] mem_addr,
  output logic                               last
);
  import accel_pkg::*;

  logic [len_width-1:0] remain;

  // one word left to fetch
  assign last = (remain == len_width'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      remain <= '0;
    end else if (load) begin
      remain <= cmd_len;
    end else if (step) begin
      remain <= remain - 1'b1;
    end
  end

  // address wraps from 255 back to 0
  always_ff @(posedge clk) begin
    if (load) begin
      mem_addr <= cmd_addr;
    end else if (step) begin
      mem_addr <= mem_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/pattern_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_match (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 rule_wr_en,
  input  logic [accel_pkg::rule_idx_width-1:0] rule_wr_addr,
  input  logic [mem_pkg::mem_data_width-1:0]   rule_wr_data,
  input  logic                                 word_valid,
  input  logic [mem_pkg::mem_data_width-1:0]   word,
  output logic                                 hit_valid,
  output logic [accel_pkg::rule_count-1:0]     hit_mask,
  output logic [accel_pkg::rule_idx_width-1:0] hit_idx
);
  import accel_pkg::*;
  import mem_pkg::*;

  logic [mem_data_width-1:0] rules [rule_count];
  logic [rule_count-1:0]     rule_vld;
  logic [rule_count-1:0]     eq;
  logic [rule_idx_width-1:0] low_idx;

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rules[rule_wr_addr] <= rule_wr_data;
    end
  end

  // a rule becomes live on the same edge it is written
  always_ff @(posedge clk) begin
    if (rst) begin
      rule_vld <= '0;
    end else if (rule_wr_en) begin
      rule_vld[rule_wr_addr] <= 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < rule_count; i++) begin
      eq[i] = rule_vld[i] && (rules[i] == word);
    end
  end

  // scan downwards so the lowest hit is left last
  always_comb begin
    low_idx = '0;
    for (int i = rule_count - 1; i >= 0; i--) begin
      if (eq[i]) begin
        low_idx = rule_idx_width'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= word_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid) begin
      hit_mask <= eq;
      hit_idx  <= low_idx;
    end
  end

endmodule

`default_nettype wire

// ==== src/accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 io_en,
  input  logic                                 io_wen,
  input  logic [accel_pkg::io_addr_width-1:0]  io_addr,
  input  logic [accel_pkg::io_data_width-1:0]  io_wr_data,
  output logic [accel_pkg::io_data_width-1:0]  io_rd_data,
  output logic                                 io_rd_valid,
  input  logic                                 rule_wr_en,
  input  logic [accel_pkg::rule_idx_width-1:0] rule_wr_addr,
  input  logic [mem_pkg::mem_data_width-1:0]   rule_wr_data,
  output logic                                 mem_en,
  output logic [mem_pkg::mem_addr_width-1:0]   mem_addr,
  input  logic [mem_pkg::mem_data_width-1:0]   mem_rd_data,
  output logic                                 error
);
  import accel_pkg::*;
  import mem_pkg::*;

  logic                      cmd_start;
  logic                      cmd_stop;
  logic [len_width-1:0]      cmd_len;
  logic [mem_addr_width-1:0] cmd_addr;
  logic                      busy;
  logic                      desc_error;
  logic                      scan_done;
  logic                      load;
  logic                      step;
  logic                      last;
  logic                      word_valid;
  logic                      hit_valid;
  logic [rule_count-1:0]     hit_mask;
  logic [rule_idx_width-1:0] hit_idx;

  // read data arrives one cycle after mem_en
  always_ff @(posedge clk) begin
    if (rst) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= mem_en;
    end
  end

  accel_regs i_accel_regs (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr), .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .cmd_start(cmd_start), .cmd_stop(cmd_stop), .cmd_len(cmd_len), .cmd_addr(cmd_addr),
    .busy(busy), .desc_error(desc_error), .scan_done(scan_done), .hit_valid(hit_valid),
    .hit_mask(hit_mask), .hit_idx(hit_idx), .error(error)
  );

  dma_ctrl i_dma_ctrl (
    .clk(clk), .rst(rst),
    .cmd_start(cmd_start), .cmd_stop(cmd_stop), .cmd_len(cmd_len), .last(last),
    .load(load), .step(step), .busy(busy), .desc_error(desc_error),
    .scan_done(scan_done), .mem_en(mem_en), .word_last()
  );

  len_counter i_len_counter (
    .clk(clk), .rst(rst), .load(load), .step(step),
    .cmd_addr(cmd_addr), .cmd_len(cmd_len), .mem_addr(mem_addr), .last(last)
  );

  pattern_match i_pattern_match (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .word_valid(word_valid), .word(mem_rd_data),
    .hit_valid(hit_valid), .hit_mask(hit_mask), .hit_idx(hit_idx)
  );

endmodule

`default_nettype wire

// ==== bench/accel_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_chk (
  input logic                                clk,
  input logic                                rst,
  input logic                                io_en,
  input logic                                io_wen,
  input logic [accel_pkg::io_addr_width-1:0] io_addr,
  input logic [accel_pkg::io_data_width-1:0] io_wr_data,
  input logic                                io_rd_valid,
  input logic                                rd_stall,
  input logic                                mem_en,
  input logic                                busy,
  input logic                                error
);
  import accel_pkg::*;

  logic err_clear;

  assign err_clear = io_en && io_wen && (io_addr == reg_err) && io_wr_data[err_bit];

  // read data follows a read strobe or a held hot read
  a_rd_valid_source: assert property (@(posedge clk) disable iff (rst)
    io_rd_valid |-> ($past(io_en && !io_wen) || $past(rd_stall)))
    else $error("io_rd_valid rose without a read request or a pending stall");

  a_mem_en_busy: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> busy)
    else $error("mem_en high while the DMA is idle");

  // only a host clear drops the sticky error
  a_error_sticky: assert property (@(posedge clk) disable iff (rst)
    (error && !err_clear) |=> error)
    else $error("error flag dropped without a clear write");

endmodule

bind accel_top accel_chk i_accel_chk (
  .clk(clk),
  .rst(rst),
  .io_en(io_en),
  .io_wen(io_wen),
  .io_addr(io_addr),
  .io_wr_data(io_wr_data),
  .io_rd_valid(io_rd_valid),
  .rd_stall(i_accel_regs.rd_stall),
  .mem_en(mem_en),
  .busy(busy),
  .error(error)
);

`default_nettype wire

// ==== bench/accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_tb;
  import accel_pkg::*;

  localparam int row_count = 6;

  logic        clk;
  logic        rst;
  logic        io_en;
  logic        io_wen;
  logic [7:0]  io_addr;
  logic [31:0] io_wr_data;
  logic [31:0] io_rd_data;
  logic        io_rd_valid;
  logic        rule_wr_en;
  logic [2:0]  rule_wr_addr;
  logic [31:0] rule_wr_data;
  logic        mem_en;
  logic [7:0]  mem_addr;
  logic [31:0] mem_rd_data;
  logic        error;

  int errors;
  int checks;
  int cycles;
  int cycle_limit;
  int cur_row;
  int fetch_count;

  logic [31:0] mem [256];
  logic        mem_en_q;
  logic [7:0]  mem_addr_q;

  // stimulus table with one entry per scan
  string row_name [row_count];
  int    row_set [row_count];
  int    row_addr [row_count];
  int    row_len [row_count];
  int    row_stop [row_count];
  int    row_busy_start [row_count];
  int    row_off0 [row_count];
  int    row_rule0 [row_count];
  int    row_off1 [row_count];
  int    row_rule1 [row_count];
  int    row_err [row_count];

  accel_top i_accel_top (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr), .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_rd_data(mem_rd_data), .error(error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // packet memory answers one cycle after mem_en and follows the fetch order
  always begin
    @(negedge clk);
    mem_en_q = mem_en;
    mem_addr_q = mem_addr;
    if (mem_en === 1'b1) begin
      check({row_name[cur_row], " fetch addr"}, (row_addr[cur_row] + fetch_count) % 256,
            mem_addr);
      fetch_count++;
    end
    @(posedge clk);
    #1;
    if (mem_en_q) begin
      mem_rd_data = mem[mem_addr_q];
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rule_word(input int set, input int r);
    return 32'hc0de_0000 | (set << 8) | r;
  endfunction

  task automatic add_row(input int i, input string name, input int set, input int addr,
                         input int len, input int stop, input int busy2, input int off0,
                         input int rule0, input int off1, input int rule1, input int err);
    row_name[i] = name;
    row_set[i] = set;
    row_addr[i] = addr;
    row_len[i] = len;
    row_stop[i] = stop;
    row_busy_start[i] = busy2;
    row_off0[i] = off0;
    row_rule0[i] = rule0;
    row_off1[i] = off1;
    row_rule1[i] = rule1;
    row_err[i] = err;
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
    io_en = 1'b1;
    io_wen = 1'b1;
    io_addr = addr;
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    io_wen = 1'b0;
  endtask

  // io_addr stays put afterwards in case the read stalls
  task automatic issue_read(input logic [7:0] addr);
    io_en = 1'b1;
    io_wen = 1'b0;
    io_addr = addr;
    @(posedge clk);
    #1;
    io_en = 1'b0;
  endtask

  task automatic wait_read(output logic [31:0] data);
    while (!io_rd_valid) begin
      @(posedge clk);
      #1;
    end
    data = io_rd_data;
  endtask

  // registers other than reg_hot answer on the next cycle
  task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
    issue_read(addr);
    check({row_name[cur_row], " read valid"}, 1, io_rd_valid);
    data = io_rd_data;
  endtask

  task automatic load_rules(input int set);
    for (int r = 0; r < rule_count; r++) begin
      rule_wr_en = 1'b1;
      rule_wr_addr = r[2:0];
      rule_wr_data = rule_word(set, r);
      @(posedge clk);
      #1;
    end
    rule_wr_en = 1'b0;
  endtask

  // hot is the OR of rule hits and idx the lowest rule of the earliest hit word
  task automatic expect_scan(input int set, input int start, input int n,
                             output logic [7:0] hot, output logic [2:0] idx,
                             output logic vld);
    logic [31:0] word;
    hot = '0;
    idx = '0;
    vld = 1'b0;
    for (int k = 0; k < n; k++) begin
      word = mem[(start + k) % 256];
      for (int r = 0; r < rule_count; r++) begin
        if (word == rule_word(set, r)) begin
          hot[r] = 1'b1;
          if (!vld) begin
            vld = 1'b1;
            idx = r[2:0];
          end
        end
      end
    end
  endtask

  task automatic run_row(input int i);
    logic [31:0] rd;
    logic [7:0]  exp_hot;
    logic [2:0]  exp_idx;
    logic        exp_vld;
    int          n;
    int          exp_fetch;
    cur_row = i;
    fetch_count = 0;
    load_rules(row_set[i]);
    if (row_off0[i] >= 0) begin
      mem[(row_addr[i] + row_off0[i]) % 256] = rule_word(row_set[i], row_rule0[i]);
    end
    if (row_off1[i] >= 0) begin
      mem[(row_addr[i] + row_off1[i]) % 256] = rule_word(row_set[i], row_rule1[i]);
    end
    host_write(reg_len, row_len[i]);
    host_write(reg_addr, row_addr[i]);
    host_read(reg_len, rd);
    check({row_name[i], " len"}, row_len[i], rd);
    host_read(reg_addr, rd);
    check({row_name[i], " addr"}, row_addr[i], rd);
    host_write(reg_ctrl, 32'd1 << ctrl_start_bit);
    if (row_len[i] == 0) begin
      host_read(reg_ctrl, rd);
      check({row_name[i], " busy"}, 0, rd[ctrl_busy_bit]);
    end else begin
      // second start lands after early hits are already recorded
      if (row_busy_start[i] > 0) begin
        repeat (row_busy_start[i]) begin
          @(posedge clk);
          #1;
        end
        host_write(reg_ctrl, 32'd1 << ctrl_start_bit);
      end
      issue_read(reg_hot);
      n = row_len[i];
      if (row_stop[i] > 0) begin
        repeat (row_stop[i]) begin
          @(posedge clk);
          #1;
        end
        host_write(reg_ctrl, 32'd1 << ctrl_stop_bit);
        io_addr = reg_hot;
        // only words whose hits land before the release are counted
        n = row_stop[i] - 1;
      end
      wait_read(rd);
      expect_scan(row_set[i], row_addr[i], n, exp_hot, exp_idx, exp_vld);
      check({row_name[i], " hot"}, exp_hot, rd);
      host_read(reg_idx, rd);
      if (exp_vld) begin
        check({row_name[i], " idx"}, (32'd1 << idx_valid_bit) | exp_idx, rd);
      end else begin
        check({row_name[i], " idx valid"}, 0, rd[idx_valid_bit]);
      end
      host_read(reg_ctrl, rd);
      check({row_name[i], " ctrl"},
            (32'd1 << ctrl_done_bit) | ((exp_hot != 0) << ctrl_match_bit), rd);
    end
    // a stop ends fetching in its own cycle, two cycles after the stalled read
    exp_fetch = (row_stop[i] > 0) ? row_stop[i] + 1 : row_len[i];
    check({row_name[i], " fetch count"}, exp_fetch, fetch_count);
    host_read(reg_err, rd);
    check({row_name[i], " err"}, row_err[i], rd);
    check({row_name[i], " error pin"}, row_err[i], error);
    if (row_err[i] != 0) begin
      host_write(reg_err, 32'd1 << err_bit);
      host_read(reg_err, rd);
      check({row_name[i], " err clear"}, 0, rd);
    end
  endtask

  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] x;
    int          total;
    rst = 1'b1;
    io_en = 1'b0;
    io_wen = 1'b0;
    io_addr = '0;
    io_wr_data = '0;
    rule_wr_en = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    cycle_limit = 0;
    cur_row = 0;
    fetch_count = 0;
    //      idx name          set addr len stop busy off0 r0 off1 r1 err
    add_row(0, "match_scan",  0,  16,  24, 0,   0,   3,   5, 10,  2, 0);
    add_row(1, "no_match",    1,  64,  32, 0,   0,   -1,  0, -1,  0, 0);
    add_row(2, "zero_len",    0,  40,  0,  0,   0,   -1,  0, -1,  0, 1);
    add_row(3, "busy_start",  0,  100, 20, 0,   14,  7,   1, -1,  0, 1);
    add_row(4, "stop_mid",    1,  150, 60, 12,  0,   2,   6, 40,  0, 0);
    add_row(5, "wrap",        0,  250, 16, 0,   0,   6,   7, 9,   4, 0);
    total = 0;
    for (int i = 0; i < row_count; i++) begin
      total += row_len[i];
    end
    cycle_limit = total + 40 * row_count + 20;
    x = 32'ha4b9f428;
    for (int a = 0; a < 256; a++) begin
      x = xorshift(x);
      mem[a] = x;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < row_count; i++) begin
      run_row(i);
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== accel_top.f ====
src/accel_pkg.sv
src/mem_pkg.sv
src/accel_regs.sv
src/dma_ctrl.sv
src/len_counter.sv
src/pattern_match.sv
src/accel_top.sv
bench/accel_chk.sv
bench/accel_tb.sv
